// ==== bench/projection_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "projection_macros.svh"

module projection_tb import projection_pkg::*; ();

    localparam real    FOCAL_LENGTH    = 0.125;
    localparam int     VIEWPORT_WIDTH  = 160;
    localparam int     VIEWPORT_HEIGHT = 120;
    localparam longint F_RAW = longint'($floor(
        FOCAL_LENGTH * real'(VIEWPORT_WIDTH) * (2.0 ** `STD_FRAC_BITS)));
    localparam longint CENTER_X = longint'(VIEWPORT_WIDTH / 2) << `STD_FRAC_BITS;
    localparam longint CENTER_Y = longint'(VIEWPORT_HEIGHT / 2) << `STD_FRAC_BITS;

    // Three divider passes plus the load and projection cycles
    localparam int LATENCY      = 3 * (`DIV_CYCLES + 1) + 2;
    localparam int N_STEADY     = 4;
    localparam int N_CLAMP      = 8;
    localparam int N_RANDOM     = 20;
    localparam int N_STALL      = 3;
    localparam int NUM_TRI      = N_STEADY + N_CLAMP + N_RANDOM + N_STALL;
    localparam int STALL_CYCLES = 400;
    localparam int READY_HIGH   = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_LOW    = 2;

    typedef struct packed {
        triangle_t      triangle;
        triangle_meta_t meta;
    } expected_t;

    logic           clk = 1'b0;
    logic           rstn;
    triangle_t      tri_in;
    triangle_meta_t tri_in_meta;
    logic           tri_in_valid;
    logic           tri_in_ready;
    triangle_t      tri_out;
    triangle_meta_t tri_out_meta;
    logic           tri_out_valid;
    logic           tri_out_ready;

    logic [31:0] lfsr_state = 32'h2f5c;
    int          ready_mode;
    logic        steady_out;
    expected_t   exp_q[$];
    expected_t   head;
    logic        head_valid = 1'b0;
    int          in_count = 0;
    int          out_count = 0;

    projection_top dut0 (
        .clk           (clk),
        .rstn          (rstn),
        .tri_in        (tri_in),
        .tri_in_meta   (tri_in_meta),
        .tri_in_valid  (tri_in_valid),
        .tri_in_ready  (tri_in_ready),
        .tri_out       (tri_out),
        .tri_out_meta  (tri_out_meta),
        .tri_out_valid (tri_out_valid),
        .tri_out_ready (tri_out_ready)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ({1'b0, s[31:1]} ^ 32'h8020_0003) : {1'b0, s[31:1]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return r;
    endfunction

    function automatic fixed_t random_coord();
        logic [31:0] b;
        b = random_bits(24);
        return fixed_t'({{8{b[23]}}, b[23:0]});
    endfunction

    // Kinds 1 to 5 fall outside or on the edge of the depth range
    function automatic fixed_t random_depth(input logic [2:0] kind);
        case (kind)
            3'd1:    return '0;
            3'd2:    return fixed_t'(-1) - fixed_t'(random_bits(24));
            3'd3:    return fixed_t'(random_bits(16));
            3'd4:    return `Z_FAR_RAW + 32'sd1 + fixed_t'(random_bits(28));
            3'd5:    return `Z_FAR_RAW;
            default: return `Z_NEAR_RAW + fixed_t'(random_bits(25));
        endcase
    endfunction

    function automatic vertex_t random_vertex(input logic any_depth);
        vertex_t    v;
        logic [2:0] kind;
        v.position.x = random_coord();
        v.position.y = random_coord();
        kind         = any_depth ? 3'(random_bits(3)) : 3'd0;
        v.position.z = random_depth(kind);
        v.color      = 16'(random_bits(16));
        return v;
    endfunction

    function automatic fixed_t clamp_depth(input fixed_t z);
        if (z < `Z_NEAR_RAW)
            return `Z_NEAR_RAW;
        else if (z > `Z_FAR_RAW)
            return `Z_FAR_RAW;
        return z;
    endfunction

    function automatic fixed_t depth_reciprocal(input fixed_t zc);
        longint dividend;
        dividend = 64'sd1 <<< 40;
        return fixed_t'(dividend / longint'(zc));
    endfunction

    function automatic fixed_t to_pixel(input fixed_t p, input fixed_t rec, input longint c);
        longint scale;
        longint sum;
        scale = (F_RAW * longint'(rec)) >>> `PREC_FRAC_BITS;
        sum   = ((scale * longint'(p)) >>> `STD_FRAC_BITS) + c;
        return fixed_t'(sum >>> (`STD_FRAC_BITS - `PIXEL_FRAC_BITS));
    endfunction

    function automatic vertex_t expected_vertex(input vertex_t v);
        vertex_t r;
        fixed_t  rec;
        rec          = depth_reciprocal(clamp_depth(v.position.z));
        r.position.x = to_pixel(v.position.x, rec, CENTER_X);
        r.position.y = to_pixel(v.position.y, rec, CENTER_Y);
        r.position.z = rec;
        r.color      = v.color;
        return r;
    endfunction

    function automatic expected_t make_expected(input triangle_t t, input triangle_meta_t m);
        expected_t e;
        e.triangle.v0 = expected_vertex(t.v0);
        e.triangle.v1 = expected_vertex(t.v1);
        e.triangle.v2 = expected_vertex(t.v2);
        e.meta        = m;
        return e;
    endfunction

    function automatic logic [31:0] word_of(input triangle_t t, input int v, input int f);
        vertex_t vx;
        case (v)
            0:       vx = t.v0;
            1:       vx = t.v1;
            default: vx = t.v2;
        endcase
        case (f)
            0:       return vx.position.x;
            1:       return vx.position.y;
            2:       return vx.position.z;
            default: return {16'h0, vx.color};
        endcase
    endfunction

    function automatic string field_name(input int f);
        case (f)
            0:       return "position.x";
            1:       return "position.y";
            2:       return "position.z";
            default: return "color";
        endcase
    endfunction

    task automatic stop_failed();
        $display("Simulation failed");
        $fatal(1);
    endtask

    // Names the first field of the output that differs
    task automatic report_output_error(input triangle_t got, input triangle_meta_t got_meta,
                                       input expected_t want, input logic want_valid);
        string       name;
        logic [31:0] got_word;
        logic [31:0] want_word;
        name      = "";
        got_word  = '0;
        want_word = '0;
        for (int v = 0; v < 3; v++) begin
            for (int f = 0; f < 4; f++) begin
                if (name == "" && word_of(got, v, f) !== word_of(want.triangle, v, f)) begin
                    name      = $sformatf("tri_out.v%0d.%s", v, field_name(f));
                    got_word  = word_of(got, v, f);
                    want_word = word_of(want.triangle, v, f);
                end
            end
        end
        if (name == "") begin
            name      = "tri_out_meta";
            got_word  = {23'h0, got_meta};
            want_word = {23'h0, want.meta};
        end
        if (!want_valid) begin
            $display("Output handshake with no triangle left to expect");
            stop_failed();
        end else begin
            $display("MISMATCH %s got %h expected %h", name, got_word, want_word);
            stop_failed();
        end
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic send_triangle(input triangle_t t, input triangle_meta_t m);
        tri_in       = t;
        tri_in_meta  = m;
        tri_in_valid = 1'b1;
        do begin
            @(posedge clk);
        end while (!tri_in_ready);
        #1;
        tri_in_valid = 1'b0;
    endtask

    task automatic run_batch(input int count, input logic any_depth, input int gap_bits);
        triangle_t      t;
        triangle_meta_t m;
        int             gap;
        for (int i = 0; i < count; i++) begin
            t.v0   = random_vertex(any_depth);
            t.v1   = random_vertex(any_depth);
            t.v2   = random_vertex(any_depth);
            m.id   = 8'(random_bits(8));
            m.last = (i == count - 1);
            send_triangle(t, m);
            gap = int'(random_bits(gap_bits));
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic wait_drain();
        do begin
            @(posedge clk);
            #1;
        end while (exp_q.size() != 0);
    endtask

    // Reference model, fed from input handshakes and drained by output ones
    always @(posedge clk) begin
        if (rstn) begin
            if (tri_out_valid && tri_out_ready) begin
                if (exp_q.size() != 0)
                    void'(exp_q.pop_front());
                out_count++;
            end
            if (tri_in_valid && tri_in_ready) begin
                exp_q.push_back(make_expected(tri_in, tri_in_meta));
                in_count++;
            end
            head_valid = (exp_q.size() != 0);
            if (head_valid)
                head = exp_q[0];
        end
    end

    // Output sink with selectable back-pressure
    initial begin
        logic next_ready;
        tri_out_ready = 1'b1;
        forever begin
            @(posedge clk);
            case (ready_mode)
                READY_RANDOM: next_ready = (random_bits(3) > 32'd2);
                READY_LOW:    next_ready = 1'b0;
                default:      next_ready = 1'b1;
            endcase
            #1;
            tri_out_ready = next_ready;
        end
    end

    a_reset_out_idle: assert property (@(posedge clk) $rose(rstn) |-> !tri_out_valid)
        else begin
            $display("MISMATCH tri_out_valid got %h expected 0", $sampled(tri_out_valid));
            stop_failed();
        end

    a_reset_in_ready: assert property (@(posedge clk) $rose(rstn) |-> tri_in_ready)
        else begin
            $display("MISMATCH tri_in_ready got %h expected 1", $sampled(tri_in_ready));
            stop_failed();
        end

    a_out_match: assert property (@(posedge clk) disable iff (!rstn)
        (tri_out_valid && tri_out_ready) |->
            (head_valid && tri_out == head.triangle && tri_out_meta == head.meta))
        else report_output_error($sampled(tri_out), $sampled(tri_out_meta),
                                 $sampled(head), $sampled(head_valid));

    a_out_stable: assert property (@(posedge clk) disable iff (!rstn)
        (tri_out_valid && !tri_out_ready) |=>
            (tri_out_valid && $stable(tri_out) && $stable(tri_out_meta)))
        else begin
            $display("Output triangle changed or was dropped while stalled");
            stop_failed();
        end

    a_latency: assert property (@(posedge clk) disable iff (!rstn)
        (tri_in_valid && tri_in_ready && steady_out) |->
            ##LATENCY !tri_out_valid ##1 tri_out_valid)
        else begin
            $display("tri_out_valid did not rise %0d cycles after the input handshake",
                     LATENCY);
            stop_failed();
        end

    a_in_ready_held: assert property (@(posedge clk) disable iff (!rstn)
        (tri_in_valid && tri_in_ready) |=> (!tri_in_ready) [*LATENCY])
        else begin
            $display("tri_in_ready rose before the job was handed on");
            stop_failed();
        end

    a_in_ready_back: assert property (@(posedge clk) disable iff (!rstn)
        (tri_in_valid && tri_in_ready && steady_out) |=>
            (!tri_in_ready) [*LATENCY] ##1 tri_in_ready)
        else begin
            $display("tri_in_ready did not return the cycle after the job handshake");
            stop_failed();
        end

    initial begin
        repeat (NUM_TRI * 200 + 1000) @(posedge clk);
        $display("Timeout, the pipeline stopped delivering triangles");
        stop_failed();
    end

    initial begin
        rstn         = 1'b0;
        tri_in       = '0;
        tri_in_meta  = '0;
        tri_in_valid = 1'b0;
        ready_mode   = READY_HIGH;
        steady_out   = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(posedge clk);
        #1;

        // Output always drained, so latency is fixed
        run_batch(N_STEADY, 1'b0, 0);
        run_batch(N_CLAMP, 1'b1, 0);
        wait_drain();

        steady_out = 1'b0;
        ready_mode = READY_RANDOM;
        run_batch(N_RANDOM, 1'b1, 3);
        wait_drain();

        // Long stall fills the output slot and parks a job in the sequencer
        ready_mode = READY_LOW;
        fork
            begin
                repeat (STALL_CYCLES) @(posedge clk);
                #1;
                ready_mode = READY_HIGH;
            end
        join_none
        run_batch(N_STALL, 1'b1, 0);
        wait_drain();
        repeat (4) @(posedge clk);

        if (in_count == NUM_TRI && out_count == NUM_TRI && exp_q.size() == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Sent %0d and received %0d triangles, expected %0d of each",
                     in_count, out_count, NUM_TRI);
            stop_failed();
        end
    end

endmodule

`default_nettype wire

// ==== design/depth_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "projection_macros.svh"

module depth_sequencer import projection_pkg::*; (
    input  logic           clk,
    input  logic           rstn,

    input  triangle_t      tri_in,
    input  triangle_meta_t tri_in_meta,
    input  logic           tri_in_valid,
    output logic           tri_in_ready,

    output logic           div_in_valid,
    input  logic           div_in_ready,
    output fixed_t         div_in_z,
    input  logic           div_out_valid,
    input  fixed_t         div_out_rec,

    output proj_job_t      job,
    output logic           job_valid,
    input  logic           job_ready
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_WAIT,
        S_OFFER
    } state_t;

    state_t    state;
    logic [1:0] idx;
    logic [1:0] z_idx;
    fixed_t    z_raw;
    proj_job_t job_q;

    // While waiting, the next vertex is offered in the result cycle
    assign z_idx = (state == S_WAIT) ? idx + 2'd1 : idx;

    always_comb begin
        case (z_idx)
            2'd0:    z_raw = job_q.triangle.v0.position.z;
            2'd1:    z_raw = job_q.triangle.v1.position.z;
            default: z_raw = job_q.triangle.v2.position.z;
        endcase
    end

    // Zero and negative depths land on the near plane
    assign div_in_z = (z_raw < `Z_NEAR_RAW) ? `Z_NEAR_RAW :
                      (z_raw > `Z_FAR_RAW)  ? `Z_FAR_RAW  : z_raw;

    assign div_in_valid = (state == S_LOAD) ||
                          (state == S_WAIT && div_out_valid && idx != 2'd2);
    assign tri_in_ready = (state == S_IDLE);
    assign job_valid    = (state == S_OFFER);
    assign job          = job_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= S_IDLE;
            idx   <= 2'd0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (tri_in_valid) begin
                        state <= S_LOAD;
                        idx   <= 2'd0;
                    end
                end
                S_LOAD: begin
                    if (div_in_ready)
                        state <= S_WAIT;
                end
                S_WAIT: begin
                    if (div_out_valid) begin
                        if (idx == 2'd2) begin
                            state <= S_OFFER;
                        end else begin
                            idx <= idx + 2'd1;
                            // Fall back to a load cycle if the divider refused
                            if (!div_in_ready)
                                state <= S_LOAD;
                        end
                    end
                end
                default: begin
                    if (job_ready)
                        state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (tri_in_valid && tri_in_ready) begin
            job_q.triangle <= tri_in;
            job_q.meta     <= tri_in_meta;
        end
        if (state == S_WAIT && div_out_valid) begin
            case (idx)
                2'd0:    job_q.rec_z0 <= div_out_rec;
                2'd1:    job_q.rec_z1 <= div_out_rec;
                default: job_q.rec_z2 <= div_out_rec;
            endcase
        end
    end

    // No new depth goes out while the divider still owes a result
    a_one_outstanding: assert property (@(posedge clk) disable iff (!rstn)
        (div_in_valid && div_in_ready) |=> (!div_in_valid) [*`DIV_CYCLES]);

endmodule

`default_nettype wire

// ==== design/projection_macros.svh ====
`ifndef PROJECTION_MACROS_SVH
`define PROJECTION_MACROS_SVH

// Fixed-point formats
// Positions, focal and center constants use 16.16
`define STD_FRAC_BITS 16

// Reciprocal of z carries 24 fractional bits
`define PREC_FRAC_BITS 24

// Projected x and y in pixels with 4 fractional bits
`define PIXEL_FRAC_BITS 4

// Depth range in 16.16 form, 1.0 and 1000.0
`define Z_NEAR_RAW 32'sh0001_0000
`define Z_FAR_RAW 32'sh03E8_0000

// One quotient bit per cycle for a 41-bit dividend of 2^40
`define DIV_CYCLES 41

`endif

// ==== design/projection_pkg.sv ====
`default_nettype none

package projection_pkg;

    // Signed fixed-point word
    typedef logic signed [31:0] fixed_t;

    // Vertex position in model space, or projected space on the output
    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
    } position_t;

    // Position plus RGB565 color
    typedef struct packed {
        position_t   position;
        logic [15:0] color;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    // Side-band data that travels with each triangle
    typedef struct packed {
        logic [7:0] id;
        logic       last;
    } triangle_meta_t;

    // Triangle with its three reciprocals, ready for projection
    typedef struct packed {
        triangle_t      triangle;
        triangle_meta_t meta;
        fixed_t         rec_z0;
        fixed_t         rec_z1;
        fixed_t         rec_z2;
    } proj_job_t;

endpackage

`default_nettype wire

// ==== design/projection_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module projection_top import projection_pkg::*; #(
    parameter real FOCAL_LENGTH    = 0.125,
    parameter int  VIEWPORT_WIDTH  = 160,
    parameter int  VIEWPORT_HEIGHT = 120
) (
    input  logic           clk,
    input  logic           rstn,

    input  triangle_t      tri_in,
    input  triangle_meta_t tri_in_meta,
    input  logic           tri_in_valid,
    output logic           tri_in_ready,

    output triangle_t      tri_out,
    output triangle_meta_t tri_out_meta,
    output logic           tri_out_valid,
    input  logic           tri_out_ready
);

    logic      div_in_valid;
    logic      div_in_ready;
    fixed_t    div_in_z;
    logic      div_out_valid;
    fixed_t    div_out_rec;
    proj_job_t job;
    logic      job_valid;
    logic      job_ready;

    depth_sequencer u_seq (
        .clk           (clk),
        .rstn          (rstn),
        .tri_in        (tri_in),
        .tri_in_meta   (tri_in_meta),
        .tri_in_valid  (tri_in_valid),
        .tri_in_ready  (tri_in_ready),
        .div_in_valid  (div_in_valid),
        .div_in_ready  (div_in_ready),
        .div_in_z      (div_in_z),
        .div_out_valid (div_out_valid),
        .div_out_rec   (div_out_rec),
        .job           (job),
        .job_valid     (job_valid),
        .job_ready     (job_ready)
    );

    reciprocal_divider u_div (
        .clk           (clk),
        .rstn          (rstn),
        .div_in_valid  (div_in_valid),
        .div_in_ready  (div_in_ready),
        .div_in_z      (div_in_z),
        .div_out_valid (div_out_valid),
        .div_out_rec   (div_out_rec)
    );

    vertex_projector #(
        .FOCAL_LENGTH    (FOCAL_LENGTH),
        .VIEWPORT_WIDTH  (VIEWPORT_WIDTH),
        .VIEWPORT_HEIGHT (VIEWPORT_HEIGHT)
    ) u_proj (
        .clk           (clk),
        .rstn          (rstn),
        .job           (job),
        .job_valid     (job_valid),
        .job_ready     (job_ready),
        .tri_out       (tri_out),
        .tri_out_meta  (tri_out_meta),
        .tri_out_valid (tri_out_valid),
        .tri_out_ready (tri_out_ready)
    );

endmodule

`default_nettype wire

// ==== design/reciprocal_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "projection_macros.svh"

module reciprocal_divider import projection_pkg::*; (
    input  logic   clk,
    input  logic   rstn,

    input  logic   div_in_valid,
    output logic   div_in_ready,
    input  fixed_t div_in_z,

    output logic   div_out_valid,
    output fixed_t div_out_rec
);

    localparam int CNT_W = $clog2(`DIV_CYCLES);

    logic                   busy;
    logic [CNT_W-1:0]       cnt;
    logic [31:0]            divisor;
    logic [31:0]            rem;
    logic [`DIV_CYCLES-1:0] num;
    logic [32:0]            trial;
    logic [32:0]            diff;
    logic                   q_bit;

    // Bring down the next dividend bit and try the subtraction
    assign trial = {rem, num[`DIV_CYCLES-1]};
    assign diff  = trial - {1'b0, divisor};
    assign q_bit = (trial >= {1'b0, divisor});

    // The divider counts as idle again during its output cycle
    assign div_in_ready = !busy;
    assign div_out_rec  = fixed_t'(num[31:0]);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy          <= 1'b0;
            cnt           <= '0;
            div_out_valid <= 1'b0;
        end else begin
            div_out_valid <= 1'b0;
            if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_W'(`DIV_CYCLES - 1)) begin
                    busy          <= 1'b0;
                    div_out_valid <= 1'b1;
                end
            end else if (div_in_valid) begin
                busy <= 1'b1;
                cnt  <= '0;
            end
        end
    end

    // Dividend shifts out at the top while quotient bits shift in below
    always_ff @(posedge clk) begin
        if (!busy && div_in_valid) begin
            divisor <= $unsigned(div_in_z);
            rem     <= '0;
            num     <= {1'b1, {(`DIV_CYCLES-1){1'b0}}};
        end else if (busy) begin
            rem <= q_bit ? diff[31:0] : trial[31:0];
            num <= {num[`DIV_CYCLES-2:0], q_bit};
        end
    end

    a_out_pulse: assert property (@(posedge clk) disable iff (!rstn)
        div_out_valid |=> !div_out_valid);

    // Once started, nothing new is taken until the result is out
    a_no_accept_busy: assert property (@(posedge clk) disable iff (!rstn)
        (div_in_valid && div_in_ready) |=>
            (!div_in_ready && !div_out_valid) [*`DIV_CYCLES] ##1 div_out_valid);

endmodule

`default_nettype wire

// ==== design/vertex_projector.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "projection_macros.svh"

module vertex_projector import projection_pkg::*; #(
    parameter real FOCAL_LENGTH    = 0.125,
    parameter int  VIEWPORT_WIDTH  = 160,
    parameter int  VIEWPORT_HEIGHT = 120
) (
    input  logic           clk,
    input  logic           rstn,

    input  proj_job_t      job,
    input  logic           job_valid,
    output logic           job_ready,

    output triangle_t      tri_out,
    output triangle_meta_t tri_out_meta,
    output logic           tri_out_valid,
    input  logic           tri_out_ready
);

    // Square pixels, so one focal constant covers x and y
    localparam fixed_t F_RAW = fixed_t'(longint'($floor(
        FOCAL_LENGTH * real'(VIEWPORT_WIDTH) * (2.0 ** `STD_FRAC_BITS))));
    localparam fixed_t CX = fixed_t'((VIEWPORT_WIDTH / 2) << `STD_FRAC_BITS);
    localparam fixed_t CY = fixed_t'((VIEWPORT_HEIGHT / 2) << `STD_FRAC_BITS);

    // p' = (f * rec) * p + c, rescaled to pixel precision
    function automatic fixed_t project(input fixed_t f, input fixed_t p,
                                       input fixed_t rec, input fixed_t c);
        longint a;
        longint s;
        a = (longint'(f) * longint'(rec)) >>> `PREC_FRAC_BITS;
        s = ((a * longint'(p)) >>> `STD_FRAC_BITS) + longint'(c);
        return fixed_t'(s >>> (`STD_FRAC_BITS - `PIXEL_FRAC_BITS));
    endfunction

    function automatic vertex_t project_vertex(input vertex_t v, input fixed_t rec);
        vertex_t r;
        r.position.x = project(F_RAW, v.position.x, rec, CX);
        r.position.y = project(F_RAW, v.position.y, rec, CY);
        r.position.z = rec;
        r.color      = v.color;
        return r;
    endfunction

    // Slot can refill in the same cycle it drains
    assign job_ready = !tri_out_valid || tri_out_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tri_out_valid <= 1'b0;
        end else if (job_valid && job_ready) begin
            tri_out_valid <= 1'b1;
        end else if (tri_out_ready) begin
            tri_out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (job_valid && job_ready) begin
            tri_out.v0   <= project_vertex(job.triangle.v0, job.rec_z0);
            tri_out.v1   <= project_vertex(job.triangle.v1, job.rec_z1);
            tri_out.v2   <= project_vertex(job.triangle.v2, job.rec_z2);
            tri_out_meta <= job.meta;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!rstn)
        (tri_out_valid && !tri_out_ready) |=>
            (tri_out_valid && $stable(tri_out) && $stable(tri_out_meta)));

endmodule

`default_nettype wire

// ==== projection.f ====
+incdir+design
design/projection_pkg.sv
design/depth_sequencer.sv
design/reciprocal_divider.sv
design/vertex_projector.sv
design/projection_top.sv
bench/projection_tb.sv
